/* sources.f */
+incdir+src
+incdir+testbench
src/ucodePkg.sv
src/ucodeEntryTable.sv
src/ucodeRom.sv
src/ucodeCtrlRegs.sv
src/ucodeSequencer.sv
src/ucodeTop.sv
testbench/ucodeTb.sv

/* src/ucodeCtrlRegs.sv */
/* Two registers at cfgAddr 0 (enable) and 1 (step limit), read back unregistered.
   Writes of zero to the step limit are dropped so the limit stays at least one */
`timescale 1ns/1ps
`default_nettype none
`include "ucode_defs.svh"

module ucodeCtrlRegs (
	input  wire logic                          clk,
	input  wire logic                          rstN,
	input  wire logic                          cfgWe,
	input  wire logic                          cfgAddr,
	input  wire logic [15:0]                   cfgWdata,
	output logic [15:0]                        cfgRdata,
	output logic                               ucodeEnable,
	output logic [`UCODE_STEPLIMIT_W-1:0]      stepLimit
);

	logic [`UCODE_STEPLIMIT_W-1:0] limitWr;

	// Only the low bits reach the limit register
	assign limitWr = cfgWdata[`UCODE_STEPLIMIT_W-1:0];

	// ==================================================
	// Register writes
	// ==================================================

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			ucodeEnable <= `UCODE_ENABLE_RESET;
			stepLimit <= `UCODE_STEPLIMIT_W'(`UCODE_STEPLIMIT_RESET);
		end else if (cfgWe) begin
			if (!cfgAddr) begin
				ucodeEnable <= cfgWdata[0];
			end else if (limitWr != '0) begin
				// A zero limit would abort before the first uop
				stepLimit <= limitWr;
			end
		end
	end

	// Read mux zero-extends both registers to the bus width
	always_comb begin
		if (cfgAddr)
			cfgRdata = {{(16 - `UCODE_STEPLIMIT_W){1'b0}}, stepLimit};
		else
			cfgRdata = {15'b0, ucodeEnable};
	end

	// The sequencer counts from one so a zero limit is never valid
	limitNonZero: assert property (@(posedge clk) disable iff (!rstN)
		stepLimit != '0)
	else
		$error("step limit register holds zero");

endmodule

`default_nettype wire

/* src/ucodeEntryTable.sv */
/* Purely combinational decode with no pipeline register.
   Unlisted opcodes and function codes map to MC_NONE and run directly */
`timescale 1ns/1ps
`default_nettype none

module ucodeEntryTable import ucodePkg::*; (
	input  wire insnWord_t insn,
	input  wire logic      stomp,
	output mcAddr_t        entryAddr
);

	// ==================================================
	// Entry address decode
	// ==================================================

	always_comb begin
		if (stomp) begin
			// A squashed instruction must not start a routine
			entryAddr = MC_NONE;
		end else begin
			casez (insn.anyFmt.opcode)
				OP_CHK:   entryAddr = MC_CHK;
				OP_ENTER: entryAddr = MC_ENTER;
				OP_LEAVE: entryAddr = MC_LEAVE;
				OP_JSRI:  entryAddr = MC_JSRI;
				OP_BCMP:  entryAddr = MC_BCMP;
				OP_BFND:  entryAddr = MC_BFND;
				// Variant 7 is the vector form and variant 0 saves all registers
				OP_PUSH:
					case (insn.anyFmt.variant)
						3'd7:    entryAddr = MC_PUSHV;
						3'd0:    entryAddr = MC_PUSHA;
						default: entryAddr = MC_PUSH;
					endcase
				OP_POP:
					case (insn.anyFmt.variant)
						3'd7:    entryAddr = MC_POPV;
						3'd0:    entryAddr = MC_POPA;
						default: entryAddr = MC_POP;
					endcase
				OP_FLT3:
					case (insn.f3Fmt.fn3)
						// Estimates pick a routine by result precision
						FN_FLT1:
							case (insn.f1Fmt.fn1)
								FN_FRES:
									case (insn.f1Fmt.prec)
										2'd0:    entryAddr = MC_FRES0;
										2'd1:    entryAddr = MC_FRES1;
										default: entryAddr = MC_FRES2;
									endcase
								FN_RSQRTE:
									case (insn.f1Fmt.prec)
										2'd0:    entryAddr = MC_RSQRTE0;
										2'd1:    entryAddr = MC_RSQRTE1;
										2'd2:    entryAddr = MC_RSQRTE2;
										default: entryAddr = MC_RSQRTE3;
									endcase
								default: entryAddr = MC_NONE;
							endcase
						FN_FDIV: entryAddr = MC_FDIV;
						default: entryAddr = MC_NONE;
					endcase
				// Only the register form of bit-field insert needs microcode
				OP_BFI:
					if (insn.anyFmt.bfiSel)
						entryAddr = MC_BFI;
					else
						entryAddr = MC_NONE;
				OP_R3V:  entryAddr = MC_R3V;
				OP_R3VS: entryAddr = MC_R3VS;
				// Whole vector group shares one routine
				7'b11?????: entryAddr = MC_VEC;
				OP_VADDSI, OP_VANDSI, OP_VORSI, OP_VEORSI:
					entryAddr = MC_VSI;
				default: entryAddr = MC_NONE;
			endcase
		end
	end

	// A nonzero address must land on a routine the ROM actually holds
	knownEntry: assert final ((entryAddr == MC_NONE) || (entryAddr inside {
		MC_ENTER, MC_PUSH, MC_POP, MC_FDIV, MC_RSQRTE0, MC_RSQRTE1, MC_RSQRTE2,
		MC_RSQRTE3, MC_FRES0, MC_FRES1, MC_FRES2, MC_JSRI, MC_CHK, MC_LEAVE,
		MC_R3V, MC_R3VS, MC_BFI, MC_VSI, MC_VEC, MC_PUSHV, MC_POPV, MC_PUSHA,
		MC_POPA, MC_BCMP, MC_BFND}))
	else
		$error("entry table produced unknown address %h", entryAddr);

endmodule

`default_nettype wire

/* src/ucodePkg.sv */
/* Opcode encodings, instruction views and microcode entry map.
   Opcodes with both top bits set are reserved for the vector group */
`default_nettype none
`include "ucode_defs.svh"

package ucodePkg;

	// ==================================================
	// Instruction encodings
	// ==================================================

	typedef enum logic [6:0] {
		OP_CHK    = 7'h01,
		OP_ENTER  = 7'h02,
		OP_LEAVE  = 7'h03,
		OP_JSRI   = 7'h04,
		OP_BCMP   = 7'h05,
		OP_BFND   = 7'h06,
		OP_PUSH   = 7'h07,
		OP_POP    = 7'h08,
		OP_FLT3   = 7'h09,
		OP_BFI    = 7'h0A,
		OP_R3V    = 7'h0B,
		OP_R3VS   = 7'h0C,
		// Vector scalar-immediate ops sit outside the 7'b11xxxxx vector group
		OP_VADDSI = 7'h10,
		OP_VANDSI = 7'h11,
		OP_VORSI  = 7'h12,
		OP_VEORSI = 7'h13
	} opcode_t;

	typedef enum logic [6:0] {
		FN_FLT1 = 7'h01,
		FN_FDIV = 7'h0C
	} fn3_t;

	typedef enum logic [5:0] {
		FN_FRES   = 6'h10,
		FN_RSQRTE = 6'h11
	} fn1_t;

	// Generic view with the variant and bit-field-insert select
	typedef struct packed {
		logic [2:0]                variant;
		logic [2:0]                rsvdHi;
		logic                      bfiSel;
		logic [`UCODE_INSN_W-15:0] rsvd;
		opcode_t                   opcode;
	} anyFmt_t;

	// Three-operand float view
	typedef struct packed {
		fn3_t                      fn3;
		logic [`UCODE_INSN_W-15:0] rsvd;
		opcode_t                   opcode;
	} f3Fmt_t;

	// Single-operand float view, only meaningful when fn3 is FN_FLT1
	typedef struct packed {
		logic [6:0]                fn3Pad;
		fn1_t                      fn1;
		logic [1:0]                prec;
		logic [`UCODE_INSN_W-23:0] rsvd;
		opcode_t                   opcode;
	} f1Fmt_t;

	typedef union packed {
		anyFmt_t anyFmt;
		f3Fmt_t  f3Fmt;
		f1Fmt_t  f1Fmt;
	} insnWord_t;

	// ==================================================
	// Microcode addresses and ROM words
	// ==================================================

	typedef logic [`UCODE_MCADDR_W-1:0] mcAddr_t;

	typedef struct packed {
		logic                    last;
		logic                    spare;
		logic [`UCODE_UOP_W-1:0] uop;
	} ucodeWord_t;

	// Address zero means the instruction runs without microcode
	localparam mcAddr_t MC_NONE    = 12'h000;

	// Routine entry points
	localparam mcAddr_t MC_ENTER   = 12'h01C;
	localparam mcAddr_t MC_PUSH    = 12'h028;
	localparam mcAddr_t MC_POP     = 12'h038;
	localparam mcAddr_t MC_FDIV    = 12'h040;
	localparam mcAddr_t MC_RSQRTE0 = 12'h050;
	localparam mcAddr_t MC_RSQRTE3 = 12'h070;
	localparam mcAddr_t MC_RSQRTE2 = 12'h080;
	localparam mcAddr_t MC_RSQRTE1 = 12'h0A0;
	localparam mcAddr_t MC_FRES0   = 12'h0C0;
	localparam mcAddr_t MC_FRES1   = 12'h0D0;
	localparam mcAddr_t MC_FRES2   = 12'h0E0;
	localparam mcAddr_t MC_JSRI    = 12'h128;
	localparam mcAddr_t MC_CHK     = 12'h130;
	localparam mcAddr_t MC_LEAVE   = 12'h1E4;
	localparam mcAddr_t MC_R3V     = 12'h200;
	localparam mcAddr_t MC_R3VS    = 12'h210;
	localparam mcAddr_t MC_BFI     = 12'h220;
	localparam mcAddr_t MC_VSI     = 12'h230;
	localparam mcAddr_t MC_VEC     = 12'h240;
	localparam mcAddr_t MC_PUSHV   = 12'h260;
	localparam mcAddr_t MC_POPV    = 12'h280;
	localparam mcAddr_t MC_PUSHA   = 12'h300;
	localparam mcAddr_t MC_POPA    = 12'h360;
	localparam mcAddr_t MC_BCMP    = 12'h3B0;
	localparam mcAddr_t MC_BFND    = 12'h3C0;

endpackage

`default_nettype wire

/* src/ucodeRom.sv */
/* Read-only and asynchronous. Addresses outside every routine read as zero
   with the last flag clear, so a stray micro-PC runs until the step limit */
`timescale 1ns/1ps
`default_nettype none
`include "ucode_defs.svh"

module ucodeRom import ucodePkg::*; (
	input  wire mcAddr_t romAddr,
	output ucodeWord_t   romWord
);

	localparam int NumRoutines = 25;
	localparam int LenW = 4;
	localparam int HalfW = `UCODE_UOP_W / 2;
	localparam int InfoW = LenW + `UCODE_MCADDR_W;

	// Routine table with the length in the top bits and the entry below
	// Index 0 is never used so that every real micro-op is nonzero
	function automatic logic [InfoW-1:0] routineInfo(input int idx);
		case (idx)
			1:       routineInfo = {4'd5, MC_ENTER};
			2:       routineInfo = {4'd4, MC_PUSH};
			3:       routineInfo = {4'd4, MC_POP};
			4:       routineInfo = {4'd9, MC_FDIV};
			5:       routineInfo = {4'd6, MC_RSQRTE0};
			6:       routineInfo = {4'd7, MC_RSQRTE3};
			7:       routineInfo = {4'd8, MC_RSQRTE2};
			8:       routineInfo = {4'd3, MC_RSQRTE1};
			9:       routineInfo = {4'd2, MC_FRES0};
			10:      routineInfo = {4'd3, MC_FRES1};
			11:      routineInfo = {4'd5, MC_FRES2};
			12:      routineInfo = {4'd6, MC_JSRI};
			13:      routineInfo = {4'd3, MC_CHK};
			14:      routineInfo = {4'd5, MC_LEAVE};
			15:      routineInfo = {4'd4, MC_R3V};
			16:      routineInfo = {4'd4, MC_R3VS};
			17:      routineInfo = {4'd7, MC_BFI};
			18:      routineInfo = {4'd5, MC_VSI};
			19:      routineInfo = {4'd4, MC_VEC};
			20:      routineInfo = {4'd8, MC_PUSHV};
			21:      routineInfo = {4'd8, MC_POPV};
			22:      routineInfo = {4'd9, MC_PUSHA};
			23:      routineInfo = {4'd9, MC_POPA};
			24:      routineInfo = {4'd6, MC_BCMP};
			25:      routineInfo = {4'd6, MC_BFND};
			default: routineInfo = '0;
		endcase
	endfunction

	// ==================================================
	// Word lookup
	// ==================================================

	always_comb begin
		logic [InfoW-1:0] info;
		logic [LenW-1:0]  len;
		mcAddr_t          offset;
		romWord = '0;
		for (int i = 1; i <= NumRoutines; i++) begin
			info = routineInfo(i);
			len = info[InfoW-1:`UCODE_MCADDR_W];
			// Unsigned wrap makes addresses below the entry fail the range test
			offset = romAddr - info[`UCODE_MCADDR_W-1:0];
			if (offset < mcAddr_t'(len)) begin
				romWord.last = (offset == mcAddr_t'(len - 1'b1));
				romWord.uop = {HalfW'(i), offset[HalfW-1:0]};
			end
		end
	end

endmodule

`default_nettype wire

/* src/ucodeSequencer.sv */
/* One routine in flight and no back-pressure. insnValid must stay low while busy
   and the ROM must answer in the same cycle as romAddr */
`timescale 1ns/1ps
`default_nettype none
`include "ucode_defs.svh"

module ucodeSequencer import ucodePkg::*; (
	input  wire logic                          clk,
	input  wire logic                          rstN,
	input  wire logic                          insnValid,
	input  wire logic                          stomp,
	input  wire mcAddr_t                       entryAddr,
	input  wire logic                          ucodeEnable,
	input  wire logic [`UCODE_STEPLIMIT_W-1:0] stepLimit,
	output mcAddr_t                            romAddr,
	input  wire ucodeWord_t                    romWord,
	output logic                               uopValid,
	output mcAddr_t                            uopAddr,
	output logic [`UCODE_UOP_W-1:0]            uop,
	output logic                               uopLast,
	output logic                               directDone,
	output logic                               abortOverrun,
	output logic                               busy
);

	logic                          active;
	logic                          directQ;
	mcAddr_t                       mpc;
	logic [`UCODE_STEPLIMIT_W-1:0] stepCnt;
	logic                          start;
	logic                          atLimit;
	logic                          finish;

	// ==================================================
	// Control decisions
	// ==================================================

	// Start a routine only from idle, with microcode on and a real entry
	assign start = insnValid && !active && ucodeEnable && (entryAddr != MC_NONE);

	// stepCnt numbers the current uop from one
	// A real last word at the limit ends normally and is not an overrun
	assign atLimit = (stepCnt >= stepLimit) && !romWord.last;

	// Current uop is the final one for any of these reasons
	assign finish = romWord.last || atLimit || stomp;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			active <= 1'b0;
			stepCnt <= '0;
			directQ <= 1'b0;
		end else begin
			// Idle instructions that do not start a routine complete directly
			directQ <= insnValid && !active && !start;
			if (active) begin
				if (finish)
					active <= 1'b0;
				else
					stepCnt <= stepCnt + 1'b1;
			end else if (start) begin
				active <= 1'b1;
				stepCnt <= `UCODE_STEPLIMIT_W'(1);
			end
		end
	end

	// Micro-PC loads the entry on start and then steps once per uop
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			mpc <= MC_NONE;
		else if (start)
			mpc <= entryAddr;
		else if (active)
			mpc <= mpc + 1'b1;
	end

	// ==================================================
	// Outputs
	// ==================================================

	assign romAddr = mpc;
	assign uopValid = active;
	assign uopAddr = mpc;
	assign uop = romWord.uop;
	// uopLast reflects the ROM flag only and aborted routines end without it
	assign uopLast = active && romWord.last;
	assign abortOverrun = active && atLimit;
	assign directDone = directQ;
	assign busy = active;

	// Both strobes come from the same instruction slot and must never overlap
	noDualStrobe: assert property (@(posedge clk) disable iff (!rstN)
		!(uopValid && directDone))
	else
		$error("uopValid and directDone high together");

	// Upstream has no stall input so it must hold off while a routine runs
	noInsnWhileBusy: assert property (@(posedge clk) disable iff (!rstN)
		insnValid |-> !busy)
	else
		$error("instruction presented while sequencer busy");

endmodule

`default_nettype wire

/* src/ucodeTop.sv */
/* Microcode front end with one instruction in flight at a time.
   Upstream must wait for busy to fall before presenting the next instruction */
`timescale 1ns/1ps
`default_nettype none
`include "ucode_defs.svh"

module ucodeTop import ucodePkg::*; (
	input  wire logic               clk,
	input  wire logic               rstN,
	input  wire logic               insnValid,
	input  wire insnWord_t          insn,
	input  wire logic               stomp,
	input  wire logic               cfgWe,
	input  wire logic               cfgAddr,
	input  wire logic [15:0]        cfgWdata,
	output logic                    uopValid,
	output mcAddr_t                 uopAddr,
	output logic [`UCODE_UOP_W-1:0] uop,
	output logic                    uopLast,
	output logic                    directDone,
	output logic                    abortOverrun,
	output logic                    busy,
	output logic [15:0]             cfgRdata
);

	mcAddr_t                       entryAddr;
	mcAddr_t                       romAddr;
	ucodeWord_t                    romWord;
	logic                          ucodeEnable;
	logic [`UCODE_STEPLIMIT_W-1:0] stepLimit;

	// Decode the opcode into a routine entry
	ucodeEntryTable uEntry (
		.insn      (insn),
		.stomp     (stomp),
		.entryAddr (entryAddr)
	);

	ucodeRom uRom (
		.romAddr (romAddr),
		.romWord (romWord)
	);

	// Software-visible enable and step limit
	ucodeCtrlRegs uRegs (
		.clk         (clk),
		.rstN        (rstN),
		.cfgWe       (cfgWe),
		.cfgAddr     (cfgAddr),
		.cfgWdata    (cfgWdata),
		.cfgRdata    (cfgRdata),
		.ucodeEnable (ucodeEnable),
		.stepLimit   (stepLimit)
	);

	ucodeSequencer uSeq (
		.clk          (clk),
		.rstN         (rstN),
		.insnValid    (insnValid),
		.stomp        (stomp),
		.entryAddr    (entryAddr),
		.ucodeEnable  (ucodeEnable),
		.stepLimit    (stepLimit),
		.romAddr      (romAddr),
		.romWord      (romWord),
		.uopValid     (uopValid),
		.uopAddr      (uopAddr),
		.uop          (uop),
		.uopLast      (uopLast),
		.directDone   (directDone),
		.abortOverrun (abortOverrun),
		.busy         (busy)
	);

endmodule

`default_nettype wire

/* src/ucode_defs.svh */
/* Widths and reset values for the microcode front end.
   The step limit reset value must be nonzero and fit in UCODE_STEPLIMIT_W bits */
`ifndef UCODE_DEFS_SVH
`define UCODE_DEFS_SVH

// Full instruction word as seen by the decode stage
`define UCODE_INSN_W 40

// Microcode ROM address width
`define UCODE_MCADDR_W 12

// Micro-op code width
// High byte is the routine index and low byte the step
`define UCODE_UOP_W 16

// Control register reset values
`define UCODE_ENABLE_RESET 1'b1
`define UCODE_STEPLIMIT_RESET 63

// Step limit register width
// It also sizes the step counter in the sequencer
`define UCODE_STEPLIMIT_W 6

`endif

/* testbench/ucodeModel.svh */
/* Reference decode and routine shapes for the testbench, included inside ucodeTb.
   Needs ucodePkg imported by the including module */
`ifndef UCODE_MODEL_SVH
`define UCODE_MODEL_SVH

// Entry address predicted from the raw instruction bits
function automatic mcAddr_t expectedEntry(input logic [39:0] w, input logic st);
	logic [6:0] op;
	logic [2:0] variant;
	logic [6:0] fn3;
	logic [5:0] fn1;
	logic [1:0] prec;
	op = w[6:0];
	variant = w[39:37];
	fn3 = w[39:33];
	fn1 = w[32:27];
	prec = w[26:25];
	expectedEntry = MC_NONE;
	if (st)
		return MC_NONE;
	// Both top opcode bits set is the vector group
	if (op[6:5] == 2'b11)
		return MC_VEC;
	case (op)
		OP_CHK:   expectedEntry = MC_CHK;
		OP_ENTER: expectedEntry = MC_ENTER;
		OP_LEAVE: expectedEntry = MC_LEAVE;
		OP_JSRI:  expectedEntry = MC_JSRI;
		OP_BCMP:  expectedEntry = MC_BCMP;
		OP_BFND:  expectedEntry = MC_BFND;
		OP_PUSH:  expectedEntry = (variant == 3'd7) ? MC_PUSHV : (variant == 3'd0) ? MC_PUSHA : MC_PUSH;
		OP_POP:   expectedEntry = (variant == 3'd7) ? MC_POPV : (variant == 3'd0) ? MC_POPA : MC_POP;
		OP_BFI:   expectedEntry = w[33] ? MC_BFI : MC_NONE;
		OP_R3V:   expectedEntry = MC_R3V;
		OP_R3VS:  expectedEntry = MC_R3VS;
		OP_VADDSI, OP_VANDSI, OP_VORSI, OP_VEORSI: expectedEntry = MC_VSI;
		OP_FLT3: begin
			if (fn3 == FN_FDIV)
				expectedEntry = MC_FDIV;
			else if (fn3 == FN_FLT1 && fn1 == FN_FRES)
				expectedEntry = (prec == 2'd0) ? MC_FRES0 : (prec == 2'd1) ? MC_FRES1 : MC_FRES2;
			else if (fn3 == FN_FLT1 && fn1 == FN_RSQRTE)
				expectedEntry = (prec == 2'd0) ? MC_RSQRTE0 : (prec == 2'd1) ? MC_RSQRTE1 :
					(prec == 2'd2) ? MC_RSQRTE2 : MC_RSQRTE3;
		end
		default: expectedEntry = MC_NONE;
	endcase
endfunction

// Routine index in the high byte and routine length in the low byte
function automatic logic [15:0] routineShape(input mcAddr_t a);
	case (a)
		MC_ENTER:   routineShape = {8'd1, 8'd5};
		MC_PUSH:    routineShape = {8'd2, 8'd4};
		MC_POP:     routineShape = {8'd3, 8'd4};
		MC_FDIV:    routineShape = {8'd4, 8'd9};
		MC_RSQRTE0: routineShape = {8'd5, 8'd6};
		MC_RSQRTE3: routineShape = {8'd6, 8'd7};
		MC_RSQRTE2: routineShape = {8'd7, 8'd8};
		MC_RSQRTE1: routineShape = {8'd8, 8'd3};
		MC_FRES0:   routineShape = {8'd9, 8'd2};
		MC_FRES1:   routineShape = {8'd10, 8'd3};
		MC_FRES2:   routineShape = {8'd11, 8'd5};
		MC_JSRI:    routineShape = {8'd12, 8'd6};
		MC_CHK:     routineShape = {8'd13, 8'd3};
		MC_LEAVE:   routineShape = {8'd14, 8'd5};
		MC_R3V:     routineShape = {8'd15, 8'd4};
		MC_R3VS:    routineShape = {8'd16, 8'd4};
		MC_BFI:     routineShape = {8'd17, 8'd7};
		MC_VSI:     routineShape = {8'd18, 8'd5};
		MC_VEC:     routineShape = {8'd19, 8'd4};
		MC_PUSHV:   routineShape = {8'd20, 8'd8};
		MC_POPV:    routineShape = {8'd21, 8'd8};
		MC_PUSHA:   routineShape = {8'd22, 8'd9};
		MC_POPA:    routineShape = {8'd23, 8'd9};
		MC_BCMP:    routineShape = {8'd24, 8'd6};
		MC_BFND:    routineShape = {8'd25, 8'd6};
		default:    routineShape = 16'h0000;
	endcase
endfunction

`endif

/* testbench/ucodeTb.sv */
/* Random instructions from a fixed seed, one in flight, checked against ucodeModel.svh.
   Stops at the first mismatch */
`timescale 1ns/1ps
`default_nettype none
`include "ucode_defs.svh"

module ucodeTb import ucodePkg::*; ();

	localparam int NumRandom = 300;
	localparam int NumDirected = 28;
	localparam int CycleLimit = (NumRandom + NumDirected) * 12 + 100;

	logic clk;
	logic rstN;
	logic insnValid;
	insnWord_t insn;
	logic stomp;
	logic cfgWe;
	logic cfgAddr;
	logic [15:0] cfgWdata;
	logic uopValid;
	mcAddr_t uopAddr;
	logic [`UCODE_UOP_W-1:0] uop;
	logic uopLast;
	logic directDone;
	logic abortOverrun;
	logic busy;
	logic [15:0] cfgRdata;

	logic [31:0] rngState;
	logic modelEnable;
	int modelLimit;
	int cycleCount = 0;
	logic [6:0] knownOps [0:15];

	`include "ucodeModel.svh"

	ucodeTop dut (.*);

	// 20 ns clock period
	always #10 clk = ~clk;

	// ==================================================
	// Random numbers and checks
	// ==================================================

	function automatic logic [31:0] nextRand();
		rngState = rngState * 32'd1103515245 + 32'd12345;
		return rngState;
	endfunction

	// Upper bits of the LCG have the longest period
	function automatic int randBelow(input int n);
		logic [31:0] r;
		r = nextRand();
		return int'(r[30:16] % n);
	endfunction

	task automatic abortRun();
		$display("SOME TESTS FAILED");
		$fatal(1, "stopping at first failure");
	endtask

	task automatic checkAddr(input string name, input mcAddr_t got, input mcAddr_t exp);
		if (got !== exp) begin
			$display("error: %s got %h expected %h", name, got, exp);
			abortRun();
		end
	endtask

	task automatic checkUop(input string name, input logic [`UCODE_UOP_W-1:0] got,
		input logic [`UCODE_UOP_W-1:0] exp);
		if (got !== exp) begin
			$display("error: %s got %h expected %h", name, got, exp);
			abortRun();
		end
	endtask

	task automatic checkReg(input string name, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp) begin
			$display("error: %s got %h expected %h", name, got, exp);
			abortRun();
		end
	endtask

	task automatic checkFlag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("error: %s got %h expected %h", name, got, exp);
			abortRun();
		end
	endtask

	// Every strobe low and the sequencer free
	task automatic checkIdle();
		checkFlag("uopValid", uopValid, 1'b0);
		checkFlag("uopLast", uopLast, 1'b0);
		checkFlag("directDone", directDone, 1'b0);
		checkFlag("abortOverrun", abortOverrun, 1'b0);
		checkFlag("busy", busy, 1'b0);
	endtask

	// ==================================================
	// Stimulus
	// ==================================================

	// Random word with a biased opcode and float function fields
	function automatic logic [39:0] makeInsn();
		logic [39:0] w;
		logic [31:0] tmp;
		int pick;
		int fnSel;
		w[31:0] = nextRand();
		tmp = nextRand();
		w[39:32] = tmp[31:24];
		pick = randBelow(20);
		fnSel = randBelow(4);
		if (pick < 16)
			w[6:0] = knownOps[pick];
		else if (pick < 18)
			w[6:0] = {2'b11, tmp[20:16]};
		else if (pick == 18)
			w[6:0] = {2'b01, tmp[12:8]};
		else begin
			w[6:0] = OP_FLT3;
			if (fnSel == 0)
				w[39:33] = FN_FDIV;
			else if (fnSel < 3) begin
				w[39:33] = FN_FLT1;
				w[32:27] = (randBelow(2) == 0) ? FN_FRES : FN_RSQRTE;
			end
		end
		return w;
	endfunction

	// Config write followed by a read-back of the same register
	task automatic cfgWrite(input logic addr, input logic [15:0] data);
		logic [15:0] expRead;
		@(posedge clk);
		#2;
		cfgWe = 1'b1;
		cfgAddr = addr;
		cfgWdata = data;
		@(posedge clk);
		#2;
		cfgWe = 1'b0;
		if (!addr)
			modelEnable = data[0];
		else if (data[5:0] != 6'd0)
			modelLimit = data[5:0];
		expRead = addr ? 16'(modelLimit) : {15'b0, modelEnable};
		@(negedge clk);
		checkReg("cfgRdata", cfgRdata, expRead);
	endtask

	// One instruction, with an optional stomp at routine step stompAt
	task automatic runInsn(input logic [39:0] w, input logic st, input int stompAt);
		mcAddr_t entry;
		logic [15:0] shape;
		int len;
		int lastStep;
		entry = expectedEntry(w, st);
		shape = routineShape(entry);
		len = shape[7:0];
		@(posedge clk);
		#2;
		insnValid = 1'b1;
		insn = w;
		stomp = st;
		@(posedge clk);
		#2;
		insnValid = 1'b0;
		stomp = 1'b0;
		if (entry == MC_NONE || !modelEnable) begin
			@(negedge clk);
			checkFlag("directDone", directDone, 1'b1);
			checkFlag("uopValid", uopValid, 1'b0);
			checkFlag("busy", busy, 1'b0);
		end else begin
			// Routine ends at its last word, the step limit or a stomp
			lastStep = (modelLimit < len) ? modelLimit : len;
			if (stompAt > 0 && stompAt < lastStep)
				lastStep = stompAt;
			for (int k = 1; k <= lastStep; k++) begin
				if (k > 1) begin
					@(posedge clk);
					#2;
				end
				stomp = (k == stompAt);
				@(negedge clk);
				checkFlag("uopValid", uopValid, 1'b1);
				checkFlag("busy", busy, 1'b1);
				checkFlag("directDone", directDone, 1'b0);
				checkAddr("uopAddr", uopAddr, entry + mcAddr_t'(k - 1));
				checkUop("uop", uop, {shape[15:8], 8'(k - 1)});
				checkFlag("uopLast", uopLast, k == len);
				checkFlag("abortOverrun", abortOverrun, k == modelLimit && modelLimit < len);
			end
		end
		// Cycle after the last response must be idle
		@(posedge clk);
		#2;
		stomp = 1'b0;
		@(negedge clk);
		checkIdle();
	endtask

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount > CycleLimit) begin
			$display("timeout: run did not finish within %0d cycles", CycleLimit);
			abortRun();
		end
	end

	// ==================================================
	// Test sequence
	// ==================================================

	initial begin
		logic [39:0] w;
		int roll;
		clk = 1'b0;
		rstN = 1'b0;
		insnValid = 1'b0;
		insn = '0;
		stomp = 1'b0;
		cfgWe = 1'b0;
		cfgAddr = 1'b0;
		cfgWdata = 16'h0000;
		rngState = 32'd97567;
		modelEnable = 1'b1;
		modelLimit = 63;
		knownOps = '{OP_CHK, OP_ENTER, OP_LEAVE, OP_JSRI, OP_BCMP, OP_BFND, OP_PUSH, OP_POP,
			OP_FLT3, OP_BFI, OP_R3V, OP_R3VS, OP_VADDSI, OP_VANDSI, OP_VORSI, OP_VEORSI};
		repeat (8) @(posedge clk);
		#2;
		rstN = 1'b1;

		// Reset values of strobes and registers
		@(negedge clk);
		checkIdle();
		checkReg("cfgRdata", cfgRdata, 16'h0001);
		@(posedge clk);
		#2;
		cfgAddr = 1'b1;
		@(negedge clk);
		checkReg("cfgRdata", cfgRdata, 16'd63);

		// Mixed traffic with stomps on the instruction and inside routines
		for (int i = 0; i < NumRandom; i++) begin
			w = makeInsn();
			roll = randBelow(16);
			runInsn(w, roll == 0, (roll == 1) ? 1 + randBelow(6) : 0);
			repeat (randBelow(2)) @(posedge clk);
		end

		// Microcode disabled then enabled again
		cfgWrite(1'b0, 16'h0000);
		for (int i = 0; i < 8; i++)
			runInsn(makeInsn(), 1'b0, 0);
		cfgWrite(1'b0, 16'h0001);
		for (int i = 0; i < 8; i++)
			runInsn(makeInsn(), 1'b0, 0);

		// Short step limit, a zero write that must be ignored, then a long routine
		cfgWrite(1'b1, 16'd3);
		cfgWrite(1'b1, 16'd0);
		w = makeInsn();
		w[6:0] = OP_PUSH;
		w[39:37] = 3'd0;
		runInsn(w, 1'b0, 0);
		for (int i = 0; i < 11; i++)
			runInsn(makeInsn(), 1'b0, 0);
		cfgWrite(1'b1, 16'd63);

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire
